// ==== source/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// line geometry
`define MEM_LINE_BITS     256
`define MEM_WORDS         8     // 32-bit words per line
`define MEM_BEATS         4     // burst beats per line
`define MEM_BEAT_BITS     64

// direct-mapped cache sets
`define MEM_SETS          16

// 32-bit address split: tag | index | offset
`define MEM_OFFSET_BITS   5
`define MEM_INDEX_BITS    4
`define MEM_TAG_BITS      23

`endif

// ==== source/mem_types_pkg.sv ====
`include "mem_params.svh"

package mem_types_pkg;

    // one cache line, seen either as words or as burst beats
    typedef union packed {
        logic [`MEM_WORDS-1:0][31:0]               words; // word adapter view
        logic [`MEM_BEATS-1:0][`MEM_BEAT_BITS-1:0] beats; // burst adapter view
    } cacheline_u;

    // byte address split for a direct-mapped lookup
    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0]    tag;
        logic [`MEM_INDEX_BITS-1:0]  index;
        logic [`MEM_OFFSET_BITS-1:0] offset;
    } addr_fields_t;

endpackage : mem_types_pkg

// ==== source/port_pkg.sv ====
`include "mem_params.svh"

package port_pkg;

    // cpu side, one 32-bit word per request
    typedef struct packed {
        logic [31:0] addr;
        logic        read;
        logic        write;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } word_req_t;

    // cache and memory side, one full line per request
    typedef struct packed {
        logic [31:0]                  addr;     // line aligned
        logic                         read;
        logic                         write;
        logic [`MEM_LINE_BITS/8-1:0]  byte_en;  // not used past the caches
        mem_types_pkg::cacheline_u    wdata;
    } line_req_t;

endpackage : port_pkg

// ==== source/word_adapter.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module word_adapter (
    input  port_pkg::word_req_t       word_req_i,
    output port_pkg::line_req_t       line_req_o,
    input  mem_types_pkg::cacheline_u line_rdata_i,
    output logic [31:0]               word_rdata_o
);

    mem_types_pkg::addr_fields_t word_addr;
    logic [2:0]                  word_sel;  // which of the eight words
    logic [`MEM_LINE_BITS/8-1:0] mask_ext;

    assign word_addr = word_req_i.addr;
    assign word_sel  = word_addr.offset[`MEM_OFFSET_BITS-1:2];
    assign mask_ext  = {{(`MEM_LINE_BITS/8-4){1'b0}}, word_req_i.wmask}; // zero extended

    always_comb begin
        line_req_o             = '0;
        line_req_o.addr        = {word_req_i.addr[31:`MEM_OFFSET_BITS], {`MEM_OFFSET_BITS{1'b0}}};
        line_req_o.read        = word_req_i.read;
        line_req_o.write       = word_req_i.write;
        // four mask bits move to the word's byte lanes
        line_req_o.byte_en     = mask_ext << {word_sel, 2'b00};
        line_req_o.wdata.words = {`MEM_WORDS{word_req_i.wdata}}; // same word in every lane
    end

    assign word_rdata_o = line_rdata_i.words[word_sel];

endmodule : word_adapter

// ==== source/line_cache.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module line_cache #(
    parameter bit READ_ONLY = 1'b0
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  port_pkg::line_req_t       cpu_req_i,
    output mem_types_pkg::cacheline_u cpu_rdata_o,
    output logic                      cpu_resp_o,
    output port_pkg::line_req_t       mem_req_o,
    input  mem_types_pkg::cacheline_u mem_rdata_i,
    input  logic                      mem_resp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_FILL
    } state_e;

    state_e                      state_q;
    logic                        resp_q;
    logic [`MEM_SETS-1:0]        valid_q;
    logic [`MEM_TAG_BITS-1:0]    tag_q [`MEM_SETS];
    mem_types_pkg::cacheline_u   data_q [`MEM_SETS];

    mem_types_pkg::addr_fields_t req_addr;
    mem_types_pkg::addr_fields_t line_addr;
    mem_types_pkg::cacheline_u   merged;
    logic                        cpu_wr;
    logic                        req_any;
    logic                        hit;
    logic                        lookup;
    logic                        wr_hit;
    logic                        fill_done;
    logic                        victim_dirty;

    assign req_addr  = cpu_req_i.addr;
    assign cpu_wr    = READ_ONLY ? 1'b0 : cpu_req_i.write;
    assign req_any   = cpu_req_i.read | cpu_wr;
    assign hit       = valid_q[req_addr.index] && (tag_q[req_addr.index] == req_addr.tag);
    // no second lookup while the resp pulse is out
    assign lookup    = (state_q == ST_IDLE) && req_any && !resp_q;
    assign wr_hit    = lookup && hit && cpu_wr;
    assign fill_done = (state_q == ST_FILL) && mem_resp_i;

    // byte merge of the write lanes into the stored line
    always_comb begin
        merged = data_q[req_addr.index];
        for (int w = 0; w < `MEM_WORDS; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (cpu_req_i.byte_en[4*w+b])
                    merged.words[w][8*b +: 8] = cpu_req_i.wdata.words[w][8*b +: 8];
            end
        end
    end

    generate
        if (READ_ONLY) begin : g_clean
            assign victim_dirty = 1'b0; // lines are never modified
        end else begin : g_dirty
            logic [`MEM_SETS-1:0] dirty_q;

            always_ff @(posedge clk) begin
                if (reset_i) begin
                    dirty_q <= '0;
                end else if (wr_hit) begin
                    dirty_q[req_addr.index] <= 1'b1;
                end else if (fill_done) begin
                    dirty_q[req_addr.index] <= 1'b0; // fresh line is clean
                end
            end

            assign victim_dirty = dirty_q[req_addr.index] & valid_q[req_addr.index];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            resp_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            resp_q <= lookup && hit;
            case (state_q)
                ST_IDLE: begin
                    if (lookup && !hit)
                        state_q <= victim_dirty ? ST_WRITEBACK : ST_FILL;
                end
                ST_WRITEBACK: begin
                    if (mem_resp_i)
                        state_q <= ST_FILL;
                end
                ST_FILL: begin
                    if (mem_resp_i) begin
                        state_q                 <= ST_IDLE; // retry lookup, hits now
                        valid_q[req_addr.index] <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            data_q[req_addr.index] <= merged;
        end else if (fill_done) begin
            data_q[req_addr.index] <= mem_rdata_i;
            tag_q[req_addr.index]  <= req_addr.tag;
        end
    end

    assign cpu_resp_o  = resp_q;
    assign cpu_rdata_o = data_q[req_addr.index]; // request is held through resp

    always_comb begin
        line_addr        = req_addr;
        line_addr.offset = '0;
        if (state_q == ST_WRITEBACK)
            line_addr.tag = tag_q[req_addr.index]; // victim's own address

        mem_req_o         = '0;
        mem_req_o.addr    = line_addr;
        mem_req_o.read    = (state_q == ST_FILL);
        mem_req_o.write   = (state_q == ST_WRITEBACK);
        mem_req_o.byte_en = '1;
        mem_req_o.wdata   = data_q[req_addr.index];
    end

    a_resp_with_req: assert property (@(posedge clk) disable iff (reset_i)
        cpu_resp_o |-> (cpu_req_i.read || cpu_req_i.write));

    a_ro_no_write: assert property (@(posedge clk) disable iff (reset_i)
        !(READ_ONLY && cpu_req_i.write));

endmodule : line_cache

// ==== source/line_arbiter.sv ====
`timescale 1ns/1ps

module line_arbiter (
    input  logic                      clk,
    input  logic                      reset_i,
    input  port_pkg::line_req_t       ireq_i,
    output mem_types_pkg::cacheline_u irdata_o,
    output logic                      iresp_o,
    input  port_pkg::line_req_t       dreq_i,
    output mem_types_pkg::cacheline_u drdata_o,
    output logic                      dresp_o,
    output port_pkg::line_req_t       mem_req_o,
    input  mem_types_pkg::cacheline_u mem_rdata_i,
    input  logic                      mem_resp_i
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_INST,
        GNT_DATA
    } grant_e;

    grant_e grant_q;
    grant_e sel;
    logic   ireq_act;
    logic   dreq_act;

    assign ireq_act = ireq_i.read | ireq_i.write;
    assign dreq_act = dreq_i.read | dreq_i.write;

    // data before instruction unless a grant is locked
    always_comb begin
        sel = grant_q;
        if (grant_q == GNT_IDLE) begin
            if (dreq_act)
                sel = GNT_DATA;
            else if (ireq_act)
                sel = GNT_INST;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            grant_q <= GNT_IDLE;
        else if (mem_resp_i)
            grant_q <= GNT_IDLE; // released by memory resp
        else
            grant_q <= sel;
    end

    always_comb begin
        case (sel)
            GNT_DATA: mem_req_o = dreq_i;
            GNT_INST: mem_req_o = ireq_i;
            default:  mem_req_o = '0;
        endcase
    end

    assign irdata_o = mem_rdata_i;
    assign drdata_o = mem_rdata_i;
    assign iresp_o  = mem_resp_i && (sel == GNT_INST);
    assign dresp_o  = mem_resp_i && (sel == GNT_DATA);

    // every memory resp reaches exactly one side
    a_one_resp: assert property (@(posedge clk) disable iff (reset_i)
        mem_resp_i |-> (iresp_o != dresp_o));

endmodule : line_arbiter

// ==== source/burst_adapter.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module burst_adapter (
    input  logic                       clk,
    input  logic                       reset_i,
    input  port_pkg::line_req_t        line_req_i,
    output mem_types_pkg::cacheline_u  line_rdata_o,
    output logic                       line_resp_o,
    output logic [31:0]                bmem_addr_o,
    output logic                       bmem_read_o,
    output logic                       bmem_write_o,
    output logic [`MEM_BEAT_BITS-1:0]  bmem_wdata_o,
    input  logic [`MEM_BEAT_BITS-1:0]  bmem_rdata_i,
    input  logic                       bmem_resp_i
);

    localparam int BEAT_W = $clog2(`MEM_BEATS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_DONE
    } state_e;

    state_e                    state_q;
    logic [BEAT_W-1:0]         beat_q;
    logic [31:0]               addr_q;
    mem_types_pkg::cacheline_u line_q;   // filled or drained one beat at a time
    logic                      last_beat;

    assign last_beat = bmem_resp_i && (beat_q == BEAT_W'(`MEM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.read)
                        state_q <= ST_READ;
                    else if (line_req_i.write)
                        state_q <= ST_WRITE;
                end
                ST_READ, ST_WRITE: begin
                    if (bmem_resp_i)
                        beat_q <= beat_q + 1'b1;
                    if (last_beat)
                        state_q <= ST_DONE;
                end
                default: state_q <= ST_IDLE; // one-cycle resp pulse
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            addr_q <= line_req_i.addr;
            if (line_req_i.write)
                line_q <= line_req_i.wdata;
        end else if (state_q == ST_READ && bmem_resp_i) begin
            line_q.beats[beat_q] <= bmem_rdata_i;
        end
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == ST_READ);
    assign bmem_write_o = (state_q == ST_WRITE);
    assign bmem_wdata_o = line_q.beats[beat_q];
    assign line_rdata_o = line_q;
    assign line_resp_o  = (state_q == ST_DONE);

    // the line requester holds its request for the whole burst
    a_req_held: assert property (@(posedge clk) disable iff (reset_i)
        (bmem_read_o || bmem_write_o) |->
            ((line_req_i.read == bmem_read_o) && (line_req_i.write == bmem_write_o)));

endmodule : burst_adapter

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_subsystem (
    input  logic                       clk,
    input  logic                       reset_i,
    input  port_pkg::word_req_t        imem_req_i,
    output logic [31:0]                imem_rdata_o,
    output logic                       imem_resp_o,
    input  port_pkg::word_req_t        dmem_req_i,
    output logic [31:0]                dmem_rdata_o,
    output logic                       dmem_resp_o,
    output logic [31:0]                bmem_addr_o,
    output logic                       bmem_read_o,
    output logic                       bmem_write_o,
    output logic [`MEM_BEAT_BITS-1:0]  bmem_wdata_o,
    input  logic [`MEM_BEAT_BITS-1:0]  bmem_rdata_i,
    input  logic                       bmem_resp_i
);

    // word adapter <-> cache
    port_pkg::line_req_t       i_line_req, d_line_req;
    mem_types_pkg::cacheline_u i_line_rdata, d_line_rdata;

    // cache <-> arbiter
    port_pkg::line_req_t       i_fill_req, d_fill_req;
    mem_types_pkg::cacheline_u i_fill_rdata, d_fill_rdata;
    logic                      i_fill_resp, d_fill_resp;

    // arbiter <-> burst adapter
    port_pkg::line_req_t       mem_req;
    mem_types_pkg::cacheline_u mem_rdata;
    logic                      mem_resp;

    word_adapter imem_adapter (
        .word_req_i   (imem_req_i),
        .line_req_o   (i_line_req),
        .line_rdata_i (i_line_rdata),
        .word_rdata_o (imem_rdata_o)
    );

    word_adapter dmem_adapter (
        .word_req_i   (dmem_req_i),
        .line_req_o   (d_line_req),
        .line_rdata_i (d_line_rdata),
        .word_rdata_o (dmem_rdata_o)
    );

    line_cache #(.READ_ONLY(1'b1)) icache (
        .clk         (clk),
        .reset_i     (reset_i),
        .cpu_req_i   (i_line_req),
        .cpu_rdata_o (i_line_rdata),
        .cpu_resp_o  (imem_resp_o),
        .mem_req_o   (i_fill_req),
        .mem_rdata_i (i_fill_rdata),
        .mem_resp_i  (i_fill_resp)
    );

    line_cache #(.READ_ONLY(1'b0)) dcache (
        .clk         (clk),
        .reset_i     (reset_i),
        .cpu_req_i   (d_line_req),
        .cpu_rdata_o (d_line_rdata),
        .cpu_resp_o  (dmem_resp_o),
        .mem_req_o   (d_fill_req),
        .mem_rdata_i (d_fill_rdata),
        .mem_resp_i  (d_fill_resp)
    );

    line_arbiter arbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .ireq_i      (i_fill_req),
        .irdata_o    (i_fill_rdata),
        .iresp_o     (i_fill_resp),
        .dreq_i      (d_fill_req),
        .drdata_o    (d_fill_rdata),
        .dresp_o     (d_fill_resp),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_resp_i  (mem_resp)
    );

    burst_adapter burst (
        .clk          (clk),
        .reset_i      (reset_i),
        .line_req_i   (mem_req),
        .line_rdata_o (mem_rdata),
        .line_resp_o  (mem_resp),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule : mem_subsystem

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 10
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(HALF_PERIOD_NS) clk_o = ~clk_o; // 20 ns period

endmodule : tb_clock

// ==== tests/burst_mem_model.sv ====
`timescale 1ns/1ps

module burst_mem_model #(
    parameter int WORDS = 4096
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [31:0] addr_i,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [63:0] wdata_i,
    output logic [63:0] rdata_o,
    output logic        resp_o
);

    logic [31:0] words [WORDS]; // shadow array that the testbench peeks
    logic [1:0]  beat;
    logic [1:0]  wait_cnt;      // cycles left before the next resp
    logic [11:0] lo_idx;
    integer      seed = 32'he5c0;

    // word index of the current beat's low half
    assign lo_idx = {addr_i[13:5], beat, 1'b0};

    initial begin
        resp_o  = 1'b0;
        rdata_o = '0;
        for (int i = 0; i < WORDS; i++)
            words[i] = (32'(i) << 2) ^ 32'hc0de_0000;
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            resp_o   <= 1'b0;
            beat     <= 2'd0;
            wait_cnt <= 2'd0;
        end else if (resp_o) begin
            if (write_i) begin // beat taken at this edge
                words[lo_idx]         <= wdata_i[31:0];
                words[lo_idx | 12'd1] <= wdata_i[63:32];
            end
            resp_o   <= 1'b0;
            beat     <= beat + 2'd1; // wraps after the fourth beat
            wait_cnt <= 2'($unsigned($random(seed)));
        end else if (read_i || write_i) begin
            if (wait_cnt == 2'd0) begin
                resp_o  <= 1'b1;
                rdata_o <= {words[lo_idx | 12'd1], words[lo_idx]};
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule : burst_mem_model

// ==== tests/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_subsystem_tb;

    localparam int NUM_ACCESSES = 8 + 17 + 5 + 18 + 8 + 200;
    // writeback plus fill, up to five cycles per beat with the resp cycle
    localparam int MISS_CYCLES  = 2 * `MEM_BEATS * 5 + 10;
    localparam int CYCLE_LIMIT  = NUM_ACCESSES * MISS_CYCLES + 20;

    logic                clk;
    logic                reset_i;
    port_pkg::word_req_t imem_req;
    port_pkg::word_req_t dmem_req;
    logic [31:0]         imem_rdata;
    logic [31:0]         dmem_rdata;
    logic                imem_resp;
    logic                dmem_resp;
    logic [31:0]         bmem_addr;
    logic                bmem_read;
    logic                bmem_write;
    logic                bmem_resp;
    logic [63:0]         bmem_wdata;
    logic [63:0]         bmem_rdata;

    logic [31:0] ref_mem [4096]; // data view of memory, word indexed
    integer      seed = 32'he5c0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    tb_clock clock_gen (.clk_o(clk));

    burst_mem_model mem_model (
        .clk_i   (clk),
        .reset_i (reset_i),
        .addr_i  (bmem_addr),
        .read_i  (bmem_read),
        .write_i (bmem_write),
        .wdata_i (bmem_wdata),
        .rdata_o (bmem_rdata),
        .resp_o  (bmem_resp)
    );

    mem_subsystem dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_req_i   (imem_req),
        .imem_rdata_o (imem_rdata),
        .imem_resp_o  (imem_resp),
        .dmem_req_i   (dmem_req),
        .dmem_rdata_o (dmem_rdata),
        .dmem_resp_o  (dmem_resp),
        .bmem_addr_o  (bmem_addr),
        .bmem_read_o  (bmem_read),
        .bmem_write_o (bmem_write),
        .bmem_wdata_o (bmem_wdata),
        .bmem_rdata_i (bmem_rdata),
        .bmem_resp_i  (bmem_resp)
    );

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return addr ^ 32'hc0de_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_word(input string what, input logic [31:0] addr,
                              input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t: %s at %h gave %h, expected %h", $time, what, addr, got, exp);
            errors++;
        end
    endtask

    task automatic report_result(input string name, input int errors_before);
        $display("%s: %0d errors", name, errors - errors_before);
    endtask

    // one request held until resp, resp sampled at the falling edge
    task automatic data_access(input logic wr, input logic [31:0] addr, input logic [3:0] mask,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        port_pkg::word_req_t req;
        req.addr  = addr;
        req.read  = !wr;
        req.write = wr;
        req.wmask = mask;
        req.wdata = wdata;
        @(posedge clk);
        dmem_req <= req;
        do
            @(negedge clk);
        while (!dmem_resp);
        rdata = dmem_rdata;
        @(posedge clk);
        dmem_req <= '0;
    endtask

    task automatic inst_access(input logic [31:0] addr, output logic [31:0] rdata);
        port_pkg::word_req_t req;
        req       = '0;
        req.addr  = addr;
        req.read  = 1'b1;
        @(posedge clk);
        imem_req <= req;
        do
            @(negedge clk);
        while (!imem_resp);
        rdata = imem_rdata;
        @(posedge clk);
        imem_req <= '0;
    endtask

    task automatic read_data(input logic [31:0] addr);
        logic [31:0] got;
        data_access(1'b0, addr, 4'h0, 32'h0, got);
        check_word("data read", addr, got, ref_mem[addr[13:2]]);
    endtask

    task automatic write_data(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] wdata);
        logic [31:0] ignored;
        data_access(1'b1, addr, mask, wdata, ignored);
        ref_mem[addr[13:2]] = merge_bytes(ref_mem[addr[13:2]], wdata, mask);
    endtask

    // instruction lines are never written back, so memory still holds the start values
    task automatic fetch_inst(input logic [31:0] addr);
        logic [31:0] got;
        inst_access(addr, got);
        check_word("inst read", addr, got, init_word(addr));
    endtask

    task automatic line_fill_reads();
        int err0;
        err0 = errors;
        for (int w = 0; w < 8; w++)
            read_data(32'h0000_0100 + 4 * w); // first one misses
        report_result("line fill reads", err0);
    endtask

    task automatic masked_byte_writes();
        int err0;
        err0 = errors;
        for (int w = 0; w < 8; w++)
            write_data(32'h0000_0140 + 4 * w, 4'(w + 1), 32'h1122_3344 + w * 32'h0101_0101);
        write_data(32'h0000_0140, 4'b1010, 32'hffee_ddcc); // second merge on word 0
        for (int w = 0; w < 8; w++)
            read_data(32'h0000_0140 + 4 * w);
        report_result("masked byte writes", err0);
    endtask

    task automatic dirty_writeback();
        int err0;
        err0 = errors;
        write_data(32'h0000_0180, 4'hf, 32'hdead_beef);
        write_data(32'h0000_0184, 4'b0110, 32'h0bad_f00d);
        read_data(32'h0000_0380); // same set, next tag
        check_word("shadow", 32'h0000_0180, mem_model.words[12'h060], ref_mem[12'h060]);
        check_word("shadow", 32'h0000_0184, mem_model.words[12'h061], ref_mem[12'h061]);
        read_data(32'h0000_0180);
        read_data(32'h0000_0184);
        report_result("dirty writeback", err0);
    endtask

    task automatic inst_only_reads();
        int err0;
        err0 = errors;
        // these stay dirty in the data cache
        write_data(32'h0000_0400, 4'hf, 32'h1234_5678);
        write_data(32'h0000_0410, 4'b0011, 32'h0000_abcd);
        for (int w = 0; w < 8; w++)
            fetch_inst(32'h0000_0400 + 4 * w);
        for (int w = 0; w < 8; w++)
            fetch_inst(32'h0000_0800 + 4 * w);
        report_result("inst only reads", err0);
    endtask

    task automatic parallel_ports();
        int err0;
        err0 = errors;
        fork
            begin
                for (int w = 0; w < 4; w++)
                    fetch_inst(32'h0000_0c00 + 4 * w);
            end
            begin
                write_data(32'h0000_1060, 4'hf, 32'h5a5a_0f0f);
                for (int w = 0; w < 3; w++)
                    read_data(32'h0000_1060 + 4 * w);
            end
        join
        report_result("parallel ports", err0);
    endtask

    task automatic random_mix();
        int          err0;
        logic [31:0] rnd;
        logic [31:0] addr;
        err0 = errors;
        for (int n = 0; n < 200; n++) begin
            rnd        = $random(seed);
            addr       = 32'h0000_2000;
            addr[10:9] = rnd[5:4]; // four tags
            addr[5]    = rnd[3];   // two sets
            addr[4:2]  = rnd[2:0];
            if (rnd[6])
                write_data(addr, rnd[10:7], $random(seed));
            else
                read_data(addr);
        end
        report_result("random mix", err0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no resp within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        reset_i  = 1'b1;
        imem_req = '0;
        dmem_req = '0;
        for (int i = 0; i < 4096; i++)
            ref_mem[i] = init_word(32'(i) << 2);
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_word("idle outputs", 32'h0,
                   {28'h0, imem_resp, dmem_resp, bmem_read, bmem_write}, 32'h0);

        line_fill_reads();
        masked_byte_writes();
        dirty_writeback();
        inst_only_reads();
        parallel_ports();
        random_mix();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule : mem_subsystem_tb

// ==== list.f ====
+incdir+source
source/mem_types_pkg.sv
source/port_pkg.sv
source/word_adapter.sv
source/line_cache.sv
source/line_arbiter.sv
source/burst_adapter.sv
source/mem_subsystem.sv
tests/tb_clock.sv
tests/burst_mem_model.sv
tests/mem_subsystem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
